//--- h2f_ipc_core.f
source/ipc_pkg.sv
source/host_register_file.sv
source/input_queue_tracker.sv
source/dispatch_control.sv
source/h2f_ipc_core.sv
testbench/ipc_checker.sv
testbench/tb_h2f_ipc_core.sv

//--- Bender.yml
package:
  name: h2f_ipc_core

sources:
  - files:
      - source/ipc_pkg.sv
      - source/host_register_file.sv
      - source/input_queue_tracker.sv
      - source/dispatch_control.sv
      - source/h2f_ipc_core.sv
  - target: test
    files:
      - testbench/ipc_checker.sv
      - testbench/tb_h2f_ipc_core.sv

//--- testbench/tb_h2f_ipc_core.sv
`timescale 1ns/1ps

module tb_h2f_ipc_core;

    localparam logic [63:0] BASE = 64'h0000_0002_8000_0000;

    logic        clk;
    logic        resetn;
    logic [31:0] waddr;
    logic [31:0] wdata;
    logic        write;
    logic [1:0]  wresp;
    logic [31:0] raddr;
    logic        read;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        tokenizer_start;
    logic [63:0] tokenizer_str_addr;
    logic        tokenizer_idle;
    logic        dispatcher_start;
    logic        dispatcher_idle;

    // Model state
    logic [15:0] lfsr;
    logic        hold_tokenizer;
    int          tok_busy;
    int          disp_busy;
    int          error_count;
    int          retired;
    int          tok_starts;
    int          tb_errors;
    int          timeouts;

    h2f_ipc_core #(
        .QUEUE_BASE  (BASE),
        .QUEUE_DEPTH (4),
        .SLOT_BYTES  (256)
    ) uut (.*);

    ipc_checker #(
        .QUEUE_BASE  (BASE),
        .QUEUE_DEPTH (4),
        .SLOT_BYTES  (256)
    ) u_checker (.*);

    always #20 clk = !clk;

    // Galois LFSR with taps 16, 14, 13 and 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    task automatic draw_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr  = lfsr_next(lfsr);
            value = (value << 1) | lfsr[0];
        end
    endtask

    // ============================== unit models
    always @(negedge clk) begin
        int r;
        if (tokenizer_start) begin
            draw_bits(3, r);
            tok_busy = r + 1;
        end else if (tok_busy > 0) begin
            tok_busy--;
        end
        if (dispatcher_start) begin
            draw_bits(3, r);
            disp_busy = r + 1;
        end else if (disp_busy > 0) begin
            disp_busy--;
        end
        tokenizer_idle  = (tok_busy == 0) && !hold_tokenizer;
        dispatcher_idle = (disp_busy == 0);
    end

    task automatic host_read(input int idx);
        @(negedge clk);
        raddr = idx << 2;
        read  = 1;
        @(negedge clk);
        read  = 0;
    endtask

    task automatic host_write(input int idx);
        @(negedge clk);
        waddr = idx << 2;
        wdata = 32'hC0DE_0000 | idx;
        write = 1;
        @(negedge clk);
        write = 0;
    endtask

    // Doorbell after fetching the slot address
    task automatic fill_slot;
        host_read(0);
        host_read(1);
        host_write(2);
    endtask

    task automatic wait_retired(input int n);
        int t;
        t = 0;
        while (retired < n && t < 2000) begin
            @(negedge clk);
            t++;
        end
        if (retired < n) begin
            timeouts++;
            $display("Timeout waiting for %0d retired slots, only %0d retired", n, retired);
        end
    endtask

    initial begin
        clk             = 0;
        resetn          = 0;
        waddr           = 0;
        wdata           = 0;
        write           = 0;
        raddr           = 0;
        read            = 0;
        tokenizer_idle  = 1;
        dispatcher_idle = 1;
        lfsr            = 16'd63;
        hold_tokenizer  = 1;
        tok_busy        = 0;
        disp_busy       = 0;
        tb_errors       = 0;
        timeouts        = 0;
        repeat (16) @(negedge clk);
        resetn = 1;
        // Low half before any latch and then the base slot
        host_read(1);
        host_read(0);
        host_read(1);
        // Fill the ring with the tokenizer held
        repeat (4) fill_slot();
        fill_slot();
        // Bad indices and wrong directions
        host_write(7);
        host_write(0);
        host_write(1);
        host_read(2);
        host_read(9);
        host_read(0);
        hold_tokenizer = 0;
        wait_retired(4);
        // Freed space and wrap around
        repeat (3) fill_slot();
        wait_retired(7);
        host_read(0);
        host_read(1);
        repeat (4) @(negedge clk);
        if (tok_starts != 7) begin
            tb_errors++;
            $display("MISMATCH at %0t ns: %0d tokenizer starts, expected 7", $time, tok_starts);
        end
        $display("Errors: checker %0d, testbench %0d, timeouts %0d",
                 error_count, tb_errors, timeouts);
        if (error_count + tb_errors + timeouts == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- testbench/ipc_checker.sv
`timescale 1ns/1ps

module ipc_checker #(
    parameter logic [ipc_pkg::QADDR_WIDTH-1:0] QUEUE_BASE  = 64'h0,
    parameter int                              QUEUE_DEPTH = 4,
    parameter int                              SLOT_BYTES  = 256
) (
    input  logic                               clk,
    input  logic                               resetn,
    input  logic [ipc_pkg::REG_DATA_WIDTH-1:0] waddr,
    input  logic                               write,
    input  logic [1:0]                         wresp,
    input  logic [ipc_pkg::REG_DATA_WIDTH-1:0] raddr,
    input  logic                               read,
    input  logic [ipc_pkg::REG_DATA_WIDTH-1:0] rdata,
    input  logic [1:0]                         rresp,
    input  logic                               tokenizer_start,
    input  logic [ipc_pkg::QADDR_WIDTH-1:0]    tokenizer_str_addr,
    input  logic                               tokenizer_idle,
    input  logic                               dispatcher_start,
    input  logic                               dispatcher_idle,
    output int                                 error_count,
    output int                                 retired,
    output int                                 tok_starts
);

    import ipc_pkg::*;

    // Reference queue state
    longint unsigned written;
    logic [63:0]     latched;
    logic [63:0]     next_a;
    logic            disp_active;
    int              disp_starts;
    logic            prev_tok_idle;
    logic            prev_disp_idle;

    // Responses owed in the next cycle
    logic            exp_r_valid;
    logic [33:0]     exp_r;
    logic            exp_w_valid;
    logic [1:0]      exp_w;

    // Slot address from a running slot number
    function automatic logic [63:0] slot_of(input longint unsigned n);
        return QUEUE_BASE + 64'((n % QUEUE_DEPTH) * SLOT_BYTES);
    endfunction

    // Expected {rresp, rdata} for a read strobe
    function automatic logic [33:0] expect_read(input logic [4:0] idx,
                                                input logic [63:0] live,
                                                input logic [63:0] held);
        if (idx == 5'd0)
            return {2'd0, live[63:32]};
        else if (idx == 5'd1)
            return {2'd0, held[31:0]};
        return {2'd3, 32'h0};
    endfunction

    // Expected wresp for a write strobe
    function automatic logic [1:0] expect_wresp(input logic [4:0] idx,
                                                input logic [63:0] held);
        if (idx != 5'd2)
            return 2'd3;
        else if (held == '1)
            return 2'd2;
        return 2'd0;
    endfunction

    always @(posedge clk) begin
        if (!resetn) begin
            written        = 0;
            retired        = 0;
            tok_starts     = 0;
            disp_starts    = 0;
            latched        = '1;
            disp_active    = 0;
            exp_r_valid    = 0;
            exp_w_valid    = 0;
            prev_tok_idle  = 0;
            prev_disp_idle = 0;
        end else begin
            // ============================== responses
            if (exp_r_valid && {rresp, rdata} !== exp_r) begin
                error_count++;
                $display("MISMATCH at %0t ns: read got resp %0d data %h, expected %0d %h",
                         $time, rresp, rdata, exp_r[33:32], exp_r[31:0]);
            end
            if (exp_w_valid && wresp !== exp_w) begin
                error_count++;
                $display("MISMATCH at %0t ns: wresp %0d, expected %0d", $time, wresp, exp_w);
            end
            exp_r_valid = read;
            exp_w_valid = write;
            // Full queue shows no address
            next_a = (written - retired == QUEUE_DEPTH) ? '1 : slot_of(written);
            // Doorbell sees the address held from an earlier high-half read
            if (write) begin
                exp_w = expect_wresp(waddr[6:2], latched);
                if (exp_w == 2'd0)
                    written++;
            end
            if (read) begin
                exp_r = expect_read(raddr[6:2], next_a, latched);
                if (raddr[6:2] == 5'd0)
                    latched = next_a;
            end
            // ============================== dispatch side
            if (tokenizer_start) begin
                tok_starts++;
                if (tokenizer_str_addr !== slot_of(retired)) begin
                    error_count++;
                    $display("MISMATCH at %0t ns: tokenizer address %h, expected %h",
                             $time, tokenizer_str_addr, slot_of(retired));
                end
            end
            if (dispatcher_start) begin
                disp_starts++;
                disp_active = 1;
                if (!(prev_tok_idle && prev_disp_idle) || disp_starts != tok_starts) begin
                    error_count++;
                    $display("MISMATCH at %0t ns: dispatcher start not after idle units",
                             $time);
                end
            end else if (disp_active && dispatcher_idle) begin
                // Slot retires on this edge
                disp_active = 0;
                retired++;
            end
            prev_tok_idle  = tokenizer_idle;
            prev_disp_idle = dispatcher_idle;
        end
    end

    initial error_count = 0;

endmodule

//--- source/h2f_ipc_core.sv
`timescale 1ns/1ps

module h2f_ipc_core #(
    parameter logic [ipc_pkg::QADDR_WIDTH-1:0] QUEUE_BASE  = 64'h0000_0010_0000_0000,
    parameter int                              QUEUE_DEPTH = 16,
    parameter int                              SLOT_BYTES  = 4096
) (
    input  logic                               clk,
    input  logic                               resetn,

    // ==============================
    // Host register port
    // ==============================
    input  logic [ipc_pkg::REG_DATA_WIDTH-1:0] waddr,
    input  logic [ipc_pkg::REG_DATA_WIDTH-1:0] wdata,
    input  logic                               write,
    output logic [1:0]                         wresp,
    input  logic [ipc_pkg::REG_DATA_WIDTH-1:0] raddr,
    input  logic                               read,
    output logic [ipc_pkg::REG_DATA_WIDTH-1:0] rdata,
    output logic [1:0]                         rresp,

    // ==============================
    // Tokenizer and dispatcher
    // ==============================
    output logic                               tokenizer_start,
    output logic [ipc_pkg::QADDR_WIDTH-1:0]    tokenizer_str_addr,
    input  logic                               tokenizer_idle,
    output logic                               dispatcher_start,
    input  logic                               dispatcher_idle
);

    import ipc_pkg::*;

    // Doorbell accepted
    logic push;

    // Slot retired
    logic pop;

    // Read side has a filled slot
    logic pending;

    // Slot addresses on both sides of the ring
    logic [QADDR_WIDTH-1:0] next_input_addr;
    logic [QADDR_WIDTH-1:0] read_slot_addr;

    // Host-facing registers and doorbell
    host_register_file u_host_register_file (
        .clk             (clk),
        .resetn          (resetn),
        .waddr           (waddr),
        .wdata           (wdata),
        .write           (write),
        .wresp           (wresp),
        .raddr           (raddr),
        .read            (read),
        .rdata           (rdata),
        .rresp           (rresp),
        .next_input_addr (next_input_addr),
        .push            (push)
    );

    // Ring indices and slot counters
    input_queue_tracker #(
        .QUEUE_BASE  (QUEUE_BASE),
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .SLOT_BYTES  (SLOT_BYTES)
    ) u_input_queue_tracker (
        .clk             (clk),
        .resetn          (resetn),
        .push            (push),
        .pop             (pop),
        .next_input_addr (next_input_addr),
        .pending         (pending),
        .read_slot_addr  (read_slot_addr)
    );

    // Tokenize, dispatch and retire in order
    dispatch_control u_dispatch_control (
        .clk                (clk),
        .resetn             (resetn),
        .pending            (pending),
        .read_slot_addr     (read_slot_addr),
        .tokenizer_start    (tokenizer_start),
        .tokenizer_str_addr (tokenizer_str_addr),
        .tokenizer_idle     (tokenizer_idle),
        .dispatcher_start   (dispatcher_start),
        .dispatcher_idle    (dispatcher_idle),
        .pop                (pop)
    );

endmodule

//--- source/dispatch_control.sv
`timescale 1ns/1ps

module dispatch_control (
    input  logic                            clk,
    input  logic                            resetn,

    // From the queue tracker
    input  logic                            pending,
    input  logic [ipc_pkg::QADDR_WIDTH-1:0] read_slot_addr,

    // Tokenizer handshake
    output logic                            tokenizer_start,
    output logic [ipc_pkg::QADDR_WIDTH-1:0] tokenizer_str_addr,
    input  logic                            tokenizer_idle,

    // Message dispatcher handshake
    output logic                            dispatcher_start,
    input  logic                            dispatcher_idle,

    // Retire the slot at the read index
    output logic                            pop
);

    // FSM states
    localparam logic [1:0] ST_IDLE     = 2'd0;
    localparam logic [1:0] ST_TOKENIZE = 2'd1;
    localparam logic [1:0] ST_DISPATCH = 2'd2;

    logic [1:0] state;

    // Both downstream units free with tokenizer idle ignored during its own start
    logic both_idle;

    assign both_idle = !tokenizer_start && tokenizer_idle && dispatcher_idle;

    // Dispatcher idle only counts once its start pulse has gone
    // Combinational so pending is fresh when the FSM returns to idle
    assign pop = (state == ST_DISPATCH) && !dispatcher_start && dispatcher_idle;

    // ==============================
    // Dispatch FSM
    // ==============================

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state            <= ST_IDLE;
            tokenizer_start  <= 1'b0;
            dispatcher_start <= 1'b0;
        end else begin
            // Start strobes last a single cycle
            tokenizer_start  <= 1'b0;
            dispatcher_start <= 1'b0;

            case (state)
                ST_IDLE: begin
                    // Oldest filled slot goes to the tokenizer
                    if (pending) begin
                        tokenizer_start <= 1'b1;
                        state           <= ST_TOKENIZE;
                    end
                end
                ST_TOKENIZE: begin
                    // Hand the message over once parsing is done
                    if (both_idle) begin
                        dispatcher_start <= 1'b1;
                        state            <= ST_DISPATCH;
                    end
                end
                ST_DISPATCH: begin
                    if (pop) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Slot address held for the tokenizer until the slot retires
    always_ff @(posedge clk) begin
        if ((state == ST_IDLE) && pending) begin
            tokenizer_str_addr <= read_slot_addr;
        end
    end

    // Start strobes never overlap and the tokenizer still sees the read slot at dispatch
    assert property (@(posedge clk) disable iff (!resetn)
        dispatcher_start |-> !tokenizer_start && (tokenizer_str_addr == read_slot_addr));

endmodule

//--- source/input_queue_tracker.sv
`timescale 1ns/1ps

module input_queue_tracker #(
    parameter logic [ipc_pkg::QADDR_WIDTH-1:0] QUEUE_BASE  = 64'h0000_0010_0000_0000,
    parameter int                              QUEUE_DEPTH = 16,
    parameter int                              SLOT_BYTES  = 4096
) (
    input  logic                            clk,
    input  logic                            resetn,

    // Slot written by the host
    input  logic                            push,

    // Slot retired by the dispatch FSM
    input  logic                            pop,

    // Write side address, NO_ADDR when full
    output logic [ipc_pkg::QADDR_WIDTH-1:0] next_input_addr,

    // Read side status and address
    output logic                            pending,
    output logic [ipc_pkg::QADDR_WIDTH-1:0] read_slot_addr
);

    import ipc_pkg::*;

    // Index width, kept at least one bit for a single-slot queue
    localparam int INDEX_WIDTH = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;

    // Slot size is a power of two, so slot offset is a shift
    localparam int SLOT_SHIFT = $clog2(SLOT_BYTES);

    localparam logic [INDEX_WIDTH-1:0] LAST_INDEX = INDEX_WIDTH'(QUEUE_DEPTH - 1);

    // Circular slot indices
    logic [INDEX_WIDTH-1:0] write_index;
    logic [INDEX_WIDTH-1:0] read_index;

    // Running totals of written and consumed slots
    logic [COUNT_WIDTH-1:0] written_count;
    logic [COUNT_WIDTH-1:0] read_count;
    logic [COUNT_WIDTH-1:0] used_count;

    logic full;

    // Step an index around the ring
    function automatic logic [INDEX_WIDTH-1:0] wrap_inc(input logic [INDEX_WIDTH-1:0] idx);
        return (idx == LAST_INDEX) ? '0 : idx + 1'b1;
    endfunction

    // Bus address of a slot
    function automatic logic [QADDR_WIDTH-1:0] slot_addr(input logic [INDEX_WIDTH-1:0] idx);
        return QUEUE_BASE + (QADDR_WIDTH'(idx) << SLOT_SHIFT);
    endfunction

    // ==============================
    // Index and count registers
    // ==============================

    always_ff @(posedge clk) begin
        if (!resetn) begin
            write_index   <= '0;
            written_count <= '0;
        end else if (push) begin
            write_index   <= wrap_inc(write_index);
            written_count <= written_count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            read_index <= '0;
            read_count <= '0;
        end else if (pop) begin
            read_index <= wrap_inc(read_index);
            read_count <= read_count + 1'b1;
        end
    end

    // ==============================
    // Status and addresses
    // ==============================

    // Slots written but not yet retired
    assign used_count = written_count - read_count;
    assign full       = (used_count == COUNT_WIDTH'(QUEUE_DEPTH));
    assign pending    = (written_count != read_count);

    assign next_input_addr = full ? NO_ADDR : slot_addr(write_index);
    assign read_slot_addr  = slot_addr(read_index);

    // Dispatch side only retires slots the host has filled
    assert property (@(posedge clk) disable iff (!resetn) pop |-> pending);

    // Host doorbells never overrun the ring
    assert property (@(posedge clk) disable iff (!resetn)
        used_count <= COUNT_WIDTH'(QUEUE_DEPTH));

endmodule

//--- source/host_register_file.sv
`timescale 1ns/1ps

module host_register_file (
    input  logic                               clk,
    input  logic                               resetn,

    // Host write strobe port
    input  logic [ipc_pkg::REG_DATA_WIDTH-1:0] waddr,
    input  logic [ipc_pkg::REG_DATA_WIDTH-1:0] wdata,
    input  logic                               write,
    output logic [1:0]                         wresp,

    // Host read strobe port
    input  logic [ipc_pkg::REG_DATA_WIDTH-1:0] raddr,
    input  logic                               read,
    output logic [ipc_pkg::REG_DATA_WIDTH-1:0] rdata,
    output logic [1:0]                         rresp,

    // From the queue tracker
    input  logic [ipc_pkg::QADDR_WIDTH-1:0]    next_input_addr,

    // One-cycle pulse on an accepted doorbell
    output logic                               push
);

    import ipc_pkg::*;

    // Register index of each access
    logic [REG_INDEX_WIDTH-1:0] wr_index;
    logic [REG_INDEX_WIDTH-1:0] rd_index;

    // Live free-slot address, split into halves
    queue_addr_u next_addr;

    // Address captured by the high-half read
    queue_addr_u latched_addr;

    // Doorbell decode
    logic doorbell_hit;
    logic addr_valid;

    // Drop the byte offset and anything above the register window
    assign wr_index = waddr[REG_INDEX_WIDTH+1:2];
    assign rd_index = raddr[REG_INDEX_WIDTH+1:2];

    assign next_addr.word = next_input_addr;

    // ==============================
    // Doorbell
    // ==============================

    // The strobe alone rings the doorbell and the payload is ignored
    assign doorbell_hit = write && (wr_index == REG_Q_WRITE);
    assign addr_valid   = (latched_addr.word != NO_ADDR);

    // Combinational so the tracker counts on the same edge as wresp
    assign push = doorbell_hit && addr_valid;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wresp <= RESP_OKAY;
        end else if (write) begin
            if (wr_index != REG_Q_WRITE) begin
                // Read-only and unmapped registers
                wresp <= RESP_DECERR;
            end else if (!addr_valid) begin
                // Host never got a free slot
                wresp <= RESP_SLVERR;
            end else begin
                wresp <= RESP_OKAY;
            end
        end
    end

    // ==============================
    // Register reads
    // ==============================

    always_ff @(posedge clk) begin
        if (!resetn) begin
            rdata             <= '0;
            rresp             <= RESP_OKAY;
            latched_addr.word <= NO_ADDR;
        end else if (read) begin
            case (rd_index)
                REG_Q_WADDR_H: begin
                    // Capture all 64 bits so the low read matches this one
                    latched_addr <= next_addr;
                    rdata        <= next_addr.half.hi;
                    rresp        <= RESP_OKAY;
                end
                REG_Q_WADDR_L: begin
                    rdata <= latched_addr.half.lo;
                    rresp <= RESP_OKAY;
                end
                default: begin
                    // Doorbell is write only and the rest is unmapped
                    rdata <= '0;
                    rresp <= RESP_DECERR;
                end
            endcase
        end
    end

    // A push only comes with a write and never lands on a full queue
    assert property (@(posedge clk) disable iff (!resetn)
        push |-> write && (next_input_addr != NO_ADDR));

endmodule

//--- source/ipc_pkg.sv
package ipc_pkg;

    // ==============================
    // Widths
    // ==============================

    // Host register data and address width
    localparam int REG_DATA_WIDTH = 32;

    // A queue address is a full 64-bit bus address
    localparam int QADDR_WIDTH = 64;

    // Slot counters never wrap in practice
    localparam int COUNT_WIDTH = 64;

    // Register index bits taken from the byte address
    // 128-byte window with the low two byte bits dropped
    localparam int REG_INDEX_WIDTH = 5;

    // ==============================
    // Register map
    // ==============================

    // Read-only high half of the next free slot address
    localparam logic [REG_INDEX_WIDTH-1:0] REG_Q_WADDR_H = 5'd0;

    // Read-only low half of the latched slot address
    localparam logic [REG_INDEX_WIDTH-1:0] REG_Q_WADDR_L = 5'd1;

    // Write-only doorbell rung after a string lands in the slot
    localparam logic [REG_INDEX_WIDTH-1:0] REG_Q_WRITE = 5'd2;

    // ==============================
    // Response codes
    // ==============================

    localparam logic [1:0] RESP_OKAY   = 2'd0;
    localparam logic [1:0] RESP_SLVERR = 2'd2;
    localparam logic [1:0] RESP_DECERR = 2'd3;

    // All ones means no free slot is available
    localparam logic [QADDR_WIDTH-1:0] NO_ADDR = '1;

    // ==============================
    // Queue address views
    // ==============================

    // Same 64 bits seen as one word or as two host-sized halves
    typedef union packed {
        logic [QADDR_WIDTH-1:0] word;
        struct packed {
            logic [REG_DATA_WIDTH-1:0] hi;
            logic [REG_DATA_WIDTH-1:0] lo;
        } half;
    } queue_addr_u;

endpackage
